// ==== adc_ctrl_top.f ====
verilog/adc_ctrl_pkg.sv
verilog/adc_regmap.sv
verilog/adc_conv_timer.sv
verilog/adc_par_bus.sv
verilog/adc_ctrl_top.sv
tb/tb_adc_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the adc control testbench with verilator and run it
# the run passes only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --top-module tb_adc_ctrl -f adc_ctrl_top.f \
  -o tb_adc_ctrl > "$BUILD_LOG" 2>&1 \
  && ./obj_dir/tb_adc_ctrl > "$SIM_LOG" 2>&1 \
  || { cat "$BUILD_LOG" "$SIM_LOG" 2>/dev/null; echo "simulation FAILED"; exit 1; }

grep -qx "Test OK" "$SIM_LOG" \
  && echo "simulation passed" \
  || { cat "$SIM_LOG"; echo "simulation FAILED"; exit 1; }

// ==== tb/tb_adc_ctrl.sv ====
/*
 * adc control testbench
 * applies a table of register and bus steps to the subsystem, with a
 * behavioral adc model driving busy and the parallel data bus
 */

module tb_adc_ctrl;

  timeunit 1ns;
  timeprecision 100ps;

  import adc_ctrl_pkg::*;

  // step kinds of the stimulus table
  typedef enum logic [3:0] {
    OP_WRITE,
    OP_READ,
    OP_WAIT,
    // write to a foreign block select, must stay unacknowledged
    OP_STRAY,
    // cnvst period and width, data holds the rate
    OP_PERIOD,
    // cnvst stays low for data cycles
    OP_QUIET,
    // end_of_conv against cnvst count over data cycles
    OP_EOC,
    OP_DEV_RD,
    OP_DEV_WR
  } op_t;

  typedef struct packed {
    op_t         op;
    reg_addr_t   addr;
    logic [31:0] data;
    logic [31:0] exp_val;
  } step_t;

  localparam int CLK_PERIOD  = 8;
  localparam int RATE        = int'(MIN_CONV_RATE) + 4;
  localparam int BUSY_CYCLES = 6;
  localparam int ACK_LIMIT   = 20;

  logic        up_clk = 1'b0;
  logic        up_resetn;
  logic        up_wreq;
  logic [13:0] up_waddr;
  logic [31:0] up_wdata;
  logic        up_wack;
  logic        up_rreq;
  logic [13:0] up_raddr;
  logic [31:0] up_rdata;
  logic        up_rack;
  logic        busy;
  logic        cnvst;
  logic        end_of_conv;
  logic [15:0] db_in;
  logic [15:0] db_out;
  logic        db_oe;
  logic        cs_n;
  logic        rd_n;
  logic        wr_n;

  // adc model state
  logic [15:0] sample;
  logic [15:0] sample_seed;
  logic        cnvst_q;
  int          busy_cnt;
  logic        wr_n_q;
  int          wr_low;
  int          wr_width;
  int          wr_pulses;
  int          oe_miss;
  logic [15:0] wr_data;

  integer      seed;
  step_t       steps[$];
  logic        steps_ready = 1'b0;

  adc_ctrl_top #(
    .ID (5)
  ) u_adc_ctrl_top (
    .up_clk      (up_clk),
    .up_resetn   (up_resetn),
    .up_wreq     (up_wreq),
    .up_waddr    (up_waddr),
    .up_wdata    (up_wdata),
    .up_wack     (up_wack),
    .up_rreq     (up_rreq),
    .up_raddr    (up_raddr),
    .up_rdata    (up_rdata),
    .up_rack     (up_rack),
    .busy        (busy),
    .cnvst       (cnvst),
    .end_of_conv (end_of_conv),
    .db_in       (db_in),
    .db_out      (db_out),
    .db_oe       (db_oe),
    .cs_n        (cs_n),
    .rd_n        (rd_n),
    .wr_n        (wr_n)
  );

  always #(CLK_PERIOD / 2) up_clk = ~up_clk;

  // ************************************************************
  // adc model
  // ************************************************************

  // busy for BUSY_CYCLES after each cnvst rise, then the next sample
  initial begin
    busy    <= 1'b0;
    db_in   <= 16'h0000;
    cnvst_q <= 1'b0;
    forever begin
      @(posedge up_clk);
      cnvst_q <= cnvst;
      if (!up_resetn) begin
        busy     <= 1'b0;
        busy_cnt <= 0;
        sample   <= sample_seed;
      end else if (cnvst && !cnvst_q) begin
        busy     <= 1'b1;
        busy_cnt <= 0;
      end else if (busy) begin
        if (busy_cnt == BUSY_CYCLES - 1) begin
          busy   <= 1'b0;
          sample <= sample + 16'd1;
        end else begin
          busy_cnt <= busy_cnt + 1;
        end
      end
      // sample shows on the bus only while rd_n is low
      db_in <= rd_n ? 16'h0000 : sample;
    end
  end

  // write strobe monitor, sampled mid cycle
  initial begin
    wr_n_q    <= 1'b1;
    wr_low    <= 0;
    wr_pulses <= 0;
    oe_miss   <= 0;
    forever begin
      @(negedge up_clk);
      wr_n_q <= wr_n;
      if (!wr_n) begin
        wr_low <= wr_low + 1;
        if (!db_oe) begin
          oe_miss <= oe_miss + 1;
        end
      end else if (!wr_n_q) begin
        // wr_n just rose, db_out still held
        wr_width  <= wr_low;
        wr_low    <= 0;
        wr_data   <= db_out;
        wr_pulses <= wr_pulses + 1;
      end
    end
  end

  // ************************************************************
  // checks
  // ************************************************************

  task automatic stop_run();
    par_state_t st;
    st = u_adc_ctrl_top.u_adc_par_bus.state;
    $display("bus engine state %s", st.name());
    $display("Test FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act);
    if (act !== exp_v) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act);
      stop_run();
    end
  endtask

  task automatic check_sample(input string name, input logic [15:0] exp_v,
                              input logic [15:0] act);
    if (act !== exp_v) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int exp_v, input int act);
    if (act != exp_v) begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp_v, act);
      stop_run();
    end
  endtask

  task automatic check_level(input string name, input logic exp_v, input logic act);
    if (act !== exp_v) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp_v, act);
      stop_run();
    end
  endtask

  // ************************************************************
  // register bus access
  // ************************************************************

  // one request pulse, then up to limit cycles for the ack
  task automatic bus_access(input logic is_rd, input logic [13:0] addr,
                            input logic [31:0] wdata, input int limit,
                            output logic acked, output int cycles,
                            output logic [31:0] rdata);
    acked  = 1'b0;
    cycles = 0;
    rdata  = 32'h0;
    @(posedge up_clk);
    if (is_rd) begin
      up_rreq  <= 1'b1;
      up_raddr <= addr;
    end else begin
      up_wreq  <= 1'b1;
      up_waddr <= addr;
      up_wdata <= wdata;
    end
    while (!acked && cycles < limit) begin
      @(posedge up_clk);
      up_rreq <= 1'b0;
      up_wreq <= 1'b0;
      cycles++;
      @(negedge up_clk);
      acked = is_rd ? up_rack : up_wack;
      rdata = up_rdata;
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
    logic        acked;
    int          cycles;
    logic [31:0] rdata;
    bus_access(1'b0, {BLOCK_SEL, addr}, data, ACK_LIMIT, acked, cycles, rdata);
    if (!acked) begin
      $display("write to %s got no up_wack", addr.name());
      stop_run();
    end
    check_count("up_wack latency", 1, cycles);
  endtask

  task automatic read_reg(input reg_addr_t addr, input logic [31:0] exp_v);
    logic        acked;
    int          cycles;
    logic [31:0] rdata;
    bus_access(1'b1, {BLOCK_SEL, addr}, 32'h0, ACK_LIMIT, acked, cycles, rdata);
    if (!acked) begin
      $display("read of %s got no up_rack", addr.name());
      stop_run();
    end
    check_count("up_rack latency", 1, cycles);
    check_word($sformatf("up_rdata %s", addr.name()), exp_v, rdata);
  endtask

  task automatic stray_write(input reg_addr_t addr, input logic [31:0] data);
    logic        acked;
    int          cycles;
    logic [31:0] rdata;
    bus_access(1'b0, {BLOCK_SEL + 6'd1, addr}, data, 10, acked, cycles, rdata);
    if (acked) begin
      $display("write outside the block select was acknowledged");
      stop_run();
    end
  endtask

  // ************************************************************
  // conversion measurements
  // ************************************************************

  task automatic measure_cnvst(input int rate);
    logic prev;
    int   n;
    int   width;
    int   period;
    @(negedge up_clk);
    n = 0;
    do begin
      prev = cnvst;
      @(negedge up_clk);
      n++;
      if (n > 2 * (rate + 1)) begin
        $display("no cnvst rise while conversions are enabled");
        stop_run();
      end
    end while (!(cnvst && !prev));
    // each pass starts on a rise and ends on the next one
    repeat (3) begin
      width  = 0;
      period = 0;
      while (cnvst && width <= rate) begin
        width++;
        period++;
        @(negedge up_clk);
      end
      while (!cnvst && period <= 2 * (rate + 1)) begin
        period++;
        @(negedge up_clk);
      end
      check_count("cnvst width", int'(CNVST_WIDTH), width);
      check_count("cnvst period", rate + 1, period);
    end
  endtask

  task automatic quiet_cnvst(input int window);
    int high;
    high = 0;
    repeat (window) begin
      @(negedge up_clk);
      if (cnvst) begin
        high++;
      end
    end
    check_count("cnvst high cycles", 0, high);
  endtask

  // pulses cut by the window edges may differ by one
  task automatic count_eoc(input int window);
    logic prev;
    int   n_cnv;
    int   n_eoc;
    int   diff;
    n_cnv = 0;
    n_eoc = 0;
    @(negedge up_clk);
    prev = cnvst;
    repeat (window) begin
      @(negedge up_clk);
      if (cnvst && !prev) begin
        n_cnv++;
      end
      if (end_of_conv) begin
        n_eoc++;
      end
      prev = cnvst;
    end
    if (n_cnv == 0) begin
      $display("no cnvst pulse inside the end of conversion window");
      stop_run();
    end
    diff = n_cnv - n_eoc;
    if (diff > 1 || diff < -1) begin
      check_count("end_of_conv pulses", n_cnv, n_eoc);
    end
  endtask

  // ************************************************************
  // device register access
  // ************************************************************

  task automatic dev_read();
    logic        acked;
    int          cycles;
    logic [31:0] rdata;
    logic [31:0] want;
    want = {16'h0000, sample};
    bus_access(1'b1, {BLOCK_SEL, REG_DEV_RD}, 32'h0, ACK_LIMIT, acked, cycles, rdata);
    if (!acked) begin
      $display("device read got no up_rack");
      stop_run();
    end
    check_count("up_rack latency", int'(PAR_STROBE) + 4, cycles);
    check_word("up_rdata REG_DEV_RD", want, rdata);
    check_level("rd_n", 1'b1, rd_n);
    check_level("cs_n", 1'b1, cs_n);
  endtask

  task automatic dev_write(input logic [31:0] data);
    int pulses0;
    int miss0;
    int n;
    pulses0 = wr_pulses;
    miss0   = oe_miss;
    write_reg(REG_DEV_WR, data);
    n = 0;
    while (wr_pulses == pulses0) begin
      @(negedge up_clk);
      n++;
      if (n > ACK_LIMIT) begin
        $display("device write produced no wr_n pulse");
        stop_run();
      end
    end
    // stray extra strobes would show up here
    repeat (6) @(negedge up_clk);
    check_count("wr_n pulses", 1, wr_pulses - pulses0);
    check_count("wr_n low cycles", int'(PAR_STROBE), wr_width);
    check_count("db_oe low during wr_n", 0, oe_miss - miss0);
    check_sample("db_out", data[15:0], wr_data);
  endtask

  // ************************************************************
  // stimulus table
  // ************************************************************

  task automatic add_step(input op_t op, input reg_addr_t addr,
                          input logic [31:0] data, input logic [31:0] exp_v);
    step_t s;
    s.op      = op;
    s.addr    = addr;
    s.data    = data;
    s.exp_val = exp_v;
    steps.push_back(s);
  endtask

  task automatic build_table();
    logic [31:0] w;
    // identity and reset values
    add_step(OP_READ, REG_VERSION, 32'h0, CORE_VERSION);
    add_step(OP_READ, REG_ID, 32'h0, 32'd5);
    add_step(OP_READ, REG_IF_TYPE, 32'h0, IF_PARALLEL);
    add_step(OP_READ, REG_CTRL, 32'h0, 32'h0);
    add_step(OP_READ, REG_CONV_RATE, 32'h0, 32'h0);
    add_step(OP_READ, REG_BURST, 32'h0, 32'h0);
    add_step(OP_STRAY, REG_SCRATCH, 32'hdead_beef, 32'h0);
    add_step(OP_READ, REG_SCRATCH, 32'h0, 32'h0);
    // readback, burst and control keep only their low bits
    w = $random(seed);
    add_step(OP_WRITE, REG_SCRATCH, w, 32'h0);
    add_step(OP_READ, REG_SCRATCH, 32'h0, w);
    w = $random(seed);
    add_step(OP_WRITE, REG_CONV_RATE, w, 32'h0);
    add_step(OP_READ, REG_CONV_RATE, 32'h0, w);
    w = $random(seed);
    add_step(OP_WRITE, REG_BURST, w, 32'h0);
    add_step(OP_READ, REG_BURST, 32'h0, {27'd0, w[4:0]});
    w = $random(seed);
    add_step(OP_WRITE, REG_CTRL, w, 32'h0);
    add_step(OP_READ, REG_CTRL, 32'h0, {30'd0, w[1:0]});
    add_step(OP_WRITE, REG_CTRL, 32'h0, 32'h0);
    // conversion pulses, then stop by enable and by soft reset
    add_step(OP_WRITE, REG_CONV_RATE, RATE, 32'h0);
    add_step(OP_WRITE, REG_CTRL, 32'd3, 32'h0);
    add_step(OP_PERIOD, REG_CTRL, RATE, 32'h0);
    add_step(OP_WRITE, REG_CTRL, 32'd1, 32'h0);
    add_step(OP_QUIET, REG_CTRL, 3 * (RATE + 1), 32'h0);
    add_step(OP_WRITE, REG_CTRL, 32'd3, 32'h0);
    add_step(OP_PERIOD, REG_CTRL, RATE, 32'h0);
    add_step(OP_WRITE, REG_CTRL, 32'd2, 32'h0);
    add_step(OP_QUIET, REG_CTRL, 3 * (RATE + 1), 32'h0);
    // end of conversion over ten periods
    add_step(OP_WRITE, REG_CTRL, 32'd3, 32'h0);
    add_step(OP_EOC, REG_CTRL, 10 * (RATE + 1), 32'h0);
    add_step(OP_WRITE, REG_CTRL, 32'h0, 32'h0);
    // let the last conversion finish so the sample holds still
    add_step(OP_WAIT, REG_CTRL, 20, 32'h0);
    add_step(OP_DEV_RD, REG_DEV_RD, 32'h0, 32'h0);
    w = $random(seed);
    add_step(OP_DEV_WR, REG_DEV_WR, w, 32'h0);
    w = $random(seed);
    add_step(OP_DEV_WR, REG_DEV_WR, w, 32'h0);
    add_step(OP_DEV_RD, REG_DEV_RD, 32'h0, 32'h0);
  endtask

  // ************************************************************
  // main sequence and watchdog
  // ************************************************************

  initial begin
    step_t s;
    seed        = 32'hdc1b;
    sample_seed = 16'($random(seed));
    build_table();
    steps_ready = 1'b1;
    up_resetn <= 1'b0;
    up_wreq   <= 1'b0;
    up_waddr  <= 14'h0;
    up_wdata  <= 32'h0;
    up_rreq   <= 1'b0;
    up_raddr  <= 14'h0;
    repeat (16) @(posedge up_clk);
    up_resetn <= 1'b1;
    repeat (4) @(posedge up_clk);
    foreach (steps[i]) begin
      s = steps[i];
      case (s.op)
        OP_WRITE:  write_reg(s.addr, s.data);
        OP_READ:   read_reg(s.addr, s.exp_val);
        OP_WAIT:   repeat (int'(s.data)) @(posedge up_clk);
        OP_STRAY:  stray_write(s.addr, s.data);
        OP_PERIOD: measure_cnvst(int'(s.data));
        OP_QUIET:  quiet_cnvst(int'(s.data));
        OP_EOC:    count_eoc(int'(s.data));
        OP_DEV_RD: dev_read();
        OP_DEV_WR: dev_write(s.data);
        default:   ;
      endcase
    end
    repeat (4) @(posedge up_clk);
    $display("Test OK");
    $finish;
  end

  // generous budget of 200 cycles per table step
  initial begin
    wait (steps_ready);
    #(steps.size() * 200 * CLK_PERIOD);
    $display("timeout, no acknowledge or pulse arrived in time");
    stop_run();
  end

endmodule

// ==== verilog/adc_conv_timer.sv ====
/*
 * adc conversion timer
 * periodic cnvst pulse generator and busy synchronizer producing
 * a one-cycle end of conversion strobe
 */

module adc_conv_timer (
  input  logic        up_clk,
  input  logic        up_resetn,

  // control from the register bank
  input  logic        ctrl_resetn,
  input  logic        cnvst_en,
  input  logic [31:0] conv_rate,

  // adc side
  input  logic        busy,
  output logic        cnvst,
  output logic        end_of_conv
);

  import adc_ctrl_pkg::*;

  logic        timer_rst;
  logic [31:0] rate_cnt;
  logic        rate_wrap;
  logic [3:0]  width_cnt;
  logic        cnvst_buf;
  logic        busy_m1;
  logic        busy_m2;
  logic        busy_d;

  // soft reset from the control register holds the whole timer
  assign timer_rst = ~up_resetn | ~ctrl_resetn;

  // ************************************************************
  // cnvst generation
  // ************************************************************

  // counter runs 0..conv_rate, period is conv_rate + 1
  assign rate_wrap = (rate_cnt >= conv_rate);

  always_ff @(posedge up_clk) begin
    if (timer_rst) begin
      rate_cnt <= 32'd0;
    end else if (rate_wrap) begin
      rate_cnt <= 32'd0;
    end else begin
      rate_cnt <= rate_cnt + 32'd1;
    end
  end

  // pulse starts on wrap and lasts CNVST_WIDTH cycles
  always_ff @(posedge up_clk) begin
    if (timer_rst) begin
      cnvst_buf <= 1'b0;
      width_cnt <= 4'd0;
    end else if (rate_wrap) begin
      cnvst_buf <= 1'b1;
      width_cnt <= 4'd0;
    end else if (cnvst_buf) begin
      if (width_cnt == CNVST_WIDTH - 4'd1) begin
        cnvst_buf <= 1'b0;
      end
      width_cnt <= width_cnt + 4'd1;
    end
  end

  // enable only masks the pin, the counter keeps its phase
  assign cnvst = cnvst_en & cnvst_buf;

  // ************************************************************
  // end of conversion
  // ************************************************************

  // two flop synchronizer, then edge register
  // eoc lands three cycles after busy falls
  always_ff @(posedge up_clk) begin
    if (timer_rst) begin
      busy_m1     <= 1'b0;
      busy_m2     <= 1'b0;
      busy_d      <= 1'b0;
      end_of_conv <= 1'b0;
    end else begin
      busy_m1     <= busy;
      busy_m2     <= busy_m1;
      busy_d      <= busy_m2;
      end_of_conv <= busy_d & ~busy_m2;
    end
  end

endmodule

// ==== verilog/adc_ctrl_pkg.sv ====
/*
 * adc control package
 * register offsets, parallel bus states and timing constants shared by the
 * register bank, the conversion timer and the parallel bus engine
 */

package adc_ctrl_pkg;

  // ************************************************************
  // register map
  // ************************************************************

  // offsets inside the block, address bits 7..0
  typedef enum logic [7:0] {
    REG_VERSION   = 8'h00,
    REG_ID        = 8'h01,
    REG_SCRATCH   = 8'h02,
    REG_IF_TYPE   = 8'h03,
    REG_CTRL      = 8'h10,
    REG_CONV_RATE = 8'h11,
    REG_BURST     = 8'h12,
    REG_DEV_RD    = 8'h13,
    REG_DEV_WR    = 8'h14
  } reg_addr_t;

  // core version, major 1 minor 1
  localparam logic [31:0] CORE_VERSION = 32'h0001_0001;

  // block select, compared against address bits 13..8
  localparam logic [5:0] BLOCK_SEL = 6'h01;

  // interface type code, only the parallel option exists
  localparam logic [31:0] IF_PARALLEL = 32'd1;

  // ************************************************************
  // parallel bus engine
  // ************************************************************

  // strobe sequencing states
  typedef enum logic [2:0] {
    PAR_IDLE,
    PAR_RD_STROBE,
    PAR_RD_CAPTURE,
    PAR_WR_STROBE,
    PAR_WR_RELEASE
  } par_state_t;

  // cycles rd_n or wr_n stays low
  localparam logic [2:0] PAR_STROBE = 3'd3;

  // ************************************************************
  // conversion timing
  // ************************************************************

  // cycles cnvst stays high per conversion
  localparam logic [3:0] CNVST_WIDTH = 4'd5;

  // smallest usable rate, the period must hold the full cnvst pulse
  // plus some margin before the next wrap
  localparam logic [31:0] MIN_CONV_RATE = 32'd8;

endpackage

// ==== verilog/adc_ctrl_top.sv ====
/*
 * adc control subsystem top
 * register bank, conversion timer and parallel bus engine
 */

module adc_ctrl_top #(
  parameter int ID = 0
) (
  input  logic        up_clk,
  input  logic        up_resetn,

  // processor register bus
  input  logic        up_wreq,
  input  logic [13:0] up_waddr,
  input  logic [31:0] up_wdata,
  output logic        up_wack,
  input  logic        up_rreq,
  input  logic [13:0] up_raddr,
  output logic [31:0] up_rdata,
  output logic        up_rack,

  // conversion control
  input  logic        busy,
  output logic        cnvst,
  output logic        end_of_conv,

  // adc parallel bus
  input  logic [15:0] db_in,
  output logic [15:0] db_out,
  output logic        db_oe,
  output logic        cs_n,
  output logic        rd_n,
  output logic        wr_n
);

  // control from the register bank
  logic        ctrl_resetn;
  logic        cnvst_en;
  logic [31:0] conv_rate;
  // stored only, no burst engine behind it
  logic [4:0]  burst_length;

  // device register access between bank and bus engine
  logic        dev_rd_req;
  logic        dev_rd_valid;
  logic [15:0] dev_rd_data;
  logic        dev_wr_req;
  logic [15:0] dev_wr_data;

  adc_regmap #(
    .ID (ID)
  ) u_adc_regmap (
    .up_clk       (up_clk),
    .up_resetn    (up_resetn),
    .up_wreq      (up_wreq),
    .up_waddr     (up_waddr),
    .up_wdata     (up_wdata),
    .up_wack      (up_wack),
    .up_rreq      (up_rreq),
    .up_raddr     (up_raddr),
    .up_rdata     (up_rdata),
    .up_rack      (up_rack),
    .ctrl_resetn  (ctrl_resetn),
    .cnvst_en     (cnvst_en),
    .conv_rate    (conv_rate),
    .burst_length (burst_length),
    .dev_rd_req   (dev_rd_req),
    .dev_rd_valid (dev_rd_valid),
    .dev_rd_data  (dev_rd_data),
    .dev_wr_req   (dev_wr_req),
    .dev_wr_data  (dev_wr_data)
  );

  adc_conv_timer u_adc_conv_timer (
    .up_clk      (up_clk),
    .up_resetn   (up_resetn),
    .ctrl_resetn (ctrl_resetn),
    .cnvst_en    (cnvst_en),
    .conv_rate   (conv_rate),
    .busy        (busy),
    .cnvst       (cnvst),
    .end_of_conv (end_of_conv)
  );

  adc_par_bus u_adc_par_bus (
    .up_clk       (up_clk),
    .up_resetn    (up_resetn),
    .dev_rd_req   (dev_rd_req),
    .dev_rd_valid (dev_rd_valid),
    .dev_rd_data  (dev_rd_data),
    .dev_wr_req   (dev_wr_req),
    .dev_wr_data  (dev_wr_data),
    .db_in        (db_in),
    .db_out       (db_out),
    .db_oe        (db_oe),
    .cs_n         (cs_n),
    .rd_n         (rd_n),
    .wr_n         (wr_n)
  );

endmodule

// ==== verilog/adc_par_bus.sv ====
/*
 * adc parallel bus engine
 * turns single device register reads and writes into cs_n, rd_n and
 * wr_n strobe sequences on the adc data bus
 */

module adc_par_bus (
  input  logic        up_clk,
  input  logic        up_resetn,

  // requests from the register bank
  input  logic        dev_rd_req,
  output logic        dev_rd_valid,
  output logic [15:0] dev_rd_data,
  input  logic        dev_wr_req,
  input  logic [15:0] dev_wr_data,

  // adc data bus
  input  logic [15:0] db_in,
  output logic [15:0] db_out,
  output logic        db_oe,
  output logic        cs_n,
  output logic        rd_n,
  output logic        wr_n
);

  import adc_ctrl_pkg::*;

  par_state_t state;
  logic [2:0] strobe_cnt;
  logic       last_low;
  logic       wr_start;

  // final low cycle of a read or write strobe
  assign last_low = (strobe_cnt == PAR_STROBE - 3'd1);

  // read wins if both arrive together
  assign wr_start = (state == PAR_IDLE) & dev_wr_req & ~dev_rd_req;

  // ************************************************************
  // strobe sequencer
  // ************************************************************

  // requests while busy are dropped, software waits for the ack
  always_ff @(posedge up_clk) begin
    if (!up_resetn) begin
      state        <= PAR_IDLE;
      strobe_cnt   <= 3'd0;
      cs_n         <= 1'b1;
      rd_n         <= 1'b1;
      wr_n         <= 1'b1;
      db_oe        <= 1'b0;
      dev_rd_valid <= 1'b0;
    end else begin
      dev_rd_valid <= 1'b0;
      case (state)
        PAR_IDLE: begin
          strobe_cnt <= 3'd0;
          if (dev_rd_req) begin
            cs_n  <= 1'b0;
            rd_n  <= 1'b0;
            state <= PAR_RD_STROBE;
          end else if (dev_wr_req) begin
            // data goes out together with the strobe
            cs_n  <= 1'b0;
            wr_n  <= 1'b0;
            db_oe <= 1'b1;
            state <= PAR_WR_STROBE;
          end
        end
        PAR_RD_STROBE: begin
          if (last_low) begin
            rd_n  <= 1'b1;
            state <= PAR_RD_CAPTURE;
          end else begin
            strobe_cnt <= strobe_cnt + 3'd1;
          end
        end
        PAR_RD_CAPTURE: begin
          // data already captured, hand it back and free the device
          cs_n         <= 1'b1;
          dev_rd_valid <= 1'b1;
          state        <= PAR_IDLE;
        end
        PAR_WR_STROBE: begin
          if (last_low) begin
            wr_n  <= 1'b1;
            state <= PAR_WR_RELEASE;
          end else begin
            strobe_cnt <= strobe_cnt + 3'd1;
          end
        end
        PAR_WR_RELEASE: begin
          // hold data one cycle past the wr_n rise
          cs_n  <= 1'b1;
          db_oe <= 1'b0;
          state <= PAR_IDLE;
        end
        default: state <= PAR_IDLE;
      endcase
    end
  end

  // ************************************************************
  // data path
  // ************************************************************

  always_ff @(posedge up_clk) begin
    if (wr_start) begin
      db_out <= dev_wr_data;
    end
    // sample on the last low cycle of rd_n
    if ((state == PAR_RD_STROBE) && last_low) begin
      dev_rd_data <= db_in;
    end
  end

endmodule

// ==== verilog/adc_regmap.sv ====
/*
 * adc register bank
 * decodes the processor register bus, holds control, rate and burst
 * registers and forwards device register accesses to the bus engine
 */

module adc_regmap #(
  parameter int ID = 0
) (
  input  logic        up_clk,
  input  logic        up_resetn,

  // processor write channel
  input  logic        up_wreq,
  input  logic [13:0] up_waddr,
  input  logic [31:0] up_wdata,
  output logic        up_wack,

  // processor read channel
  input  logic        up_rreq,
  input  logic [13:0] up_raddr,
  output logic [31:0] up_rdata,
  output logic        up_rack,

  // control outputs
  output logic        ctrl_resetn,
  output logic        cnvst_en,
  output logic [31:0] conv_rate,
  output logic [4:0]  burst_length,

  // device register access
  output logic        dev_rd_req,
  input  logic        dev_rd_valid,
  input  logic [15:0] dev_rd_data,
  output logic        dev_wr_req,
  output logic [15:0] dev_wr_data
);

  import adc_ctrl_pkg::*;

  logic        wreq_s;
  logic        rreq_s;
  reg_addr_t   waddr_s;
  reg_addr_t   raddr_s;
  logic        rreq_dev_s;
  logic        wreq_dev_s;
  logic        dev_rd_pend;
  logic [31:0] scratch;
  logic [31:0] rdata_s;

  // ************************************************************
  // block decode
  // ************************************************************

  // requests outside this block are ignored and never acknowledged
  assign wreq_s = up_wreq & (up_waddr[13:8] == BLOCK_SEL);
  assign rreq_s = up_rreq & (up_raddr[13:8] == BLOCK_SEL);

  assign waddr_s = reg_addr_t'(up_waddr[7:0]);
  assign raddr_s = reg_addr_t'(up_raddr[7:0]);

  // device register hits
  assign rreq_dev_s = rreq_s & (raddr_s == REG_DEV_RD);
  assign wreq_dev_s = wreq_s & (waddr_s == REG_DEV_WR);

  // ************************************************************
  // write side
  // ************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_resetn) begin
      up_wack      <= 1'b0;
      scratch      <= 32'd0;
      ctrl_resetn  <= 1'b0;
      cnvst_en     <= 1'b0;
      conv_rate    <= 32'd0;
      burst_length <= 5'd0;
      dev_wr_req   <= 1'b0;
    end else begin
      up_wack    <= wreq_s;
      // one cycle after the write, data register already loaded
      dev_wr_req <= wreq_dev_s;
      if (wreq_s) begin
        case (waddr_s)
          REG_SCRATCH:   scratch <= up_wdata;
          REG_CTRL: begin
            // bit 0 soft reset (active low), bit 1 conversion enable
            ctrl_resetn <= up_wdata[0];
            cnvst_en    <= up_wdata[1];
          end
          REG_CONV_RATE: conv_rate <= up_wdata;
          REG_BURST:     burst_length <= up_wdata[4:0];
          // if type and read-only offsets take no write
          default: ;
        endcase
      end
    end
  end

  // device write data, only meaningful with dev_wr_req
  always_ff @(posedge up_clk) begin
    if (wreq_dev_s) begin
      dev_wr_data <= up_wdata[15:0];
    end
  end

  // ************************************************************
  // read side
  // ************************************************************

  // register read mux, unmapped offsets read as zero
  always_comb begin
    case (raddr_s)
      REG_VERSION:   rdata_s = CORE_VERSION;
      REG_ID:        rdata_s = 32'(ID);
      REG_SCRATCH:   rdata_s = scratch;
      REG_IF_TYPE:   rdata_s = IF_PARALLEL;
      REG_CTRL:      rdata_s = {30'd0, cnvst_en, ctrl_resetn};
      REG_CONV_RATE: rdata_s = conv_rate;
      REG_BURST:     rdata_s = {27'd0, burst_length};
      default:       rdata_s = 32'd0;
    endcase
  end

  // plain registers ack next cycle
  // the device register waits for the bus engine to return data
  always_ff @(posedge up_clk) begin
    if (!up_resetn) begin
      up_rack     <= 1'b0;
      dev_rd_req  <= 1'b0;
      dev_rd_pend <= 1'b0;
    end else begin
      dev_rd_req <= rreq_dev_s;
      up_rack    <= (rreq_s & ~rreq_dev_s) | (dev_rd_pend & dev_rd_valid);
      if (rreq_dev_s) begin
        dev_rd_pend <= 1'b1;
      end else if (dev_rd_valid) begin
        dev_rd_pend <= 1'b0;
      end
    end
  end

  // read data, valid together with up_rack
  always_ff @(posedge up_clk) begin
    if (dev_rd_pend && dev_rd_valid) begin
      up_rdata <= {16'd0, dev_rd_data};
    end else if (rreq_s) begin
      up_rdata <= rdata_s;
    end
  end

endmodule
